// File: hw/rv32e_consts.svh
//////////////////////////////////////////////////////////////////////
// shared constants for the RV32E system-instruction decode stage
// widths, CSR addresses, SYSTEM encodings and CSR reset values
//////////////////////////////////////////////////////////////////////

`ifndef RV32E_CONSTS_SVH
`define RV32E_CONSTS_SVH

// datapath width and register count
`define XLEN            32
// RV32E only has x0..x15
`define NUM_GPR         16

// machine CSR addresses
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

// major opcode of ecall, mret and the csr ops
`define OPC_SYSTEM      7'b1110011

// funct3 codes inside SYSTEM
`define F3_PRIV         3'd0
`define F3_CSRRW        3'd1
`define F3_CSRRS        3'd2

// priv immediates, funct3 == 0
`define IMM_ECALL       12'h000
`define IMM_MRET        12'h302

// CSR reset values
// MPP = 2'b11, machine mode
`define MSTATUS_RST     32'h0000_1800
`define MCAUSE_RST      32'd11

// environment call from M-mode
`define CAUSE_ECALL_M   32'd11

`endif

// File: hw/rv32e_pkg.sv
//////////////////////////////////////////////////////////////////////
// types shared by the decoder, register file, CSR file and top
//////////////////////////////////////////////////////////////////////

package rv32e_pkg;

    // decoded SYSTEM operation
    // op_none covers illegal instructions too
    typedef enum logic [2:0] {
        op_none  = 3'd0,
        op_ecall = 3'd1,
        op_mret  = 3'd2,
        op_csrrw = 3'd3,
        op_csrrs = 3'd4
    } sys_op_t;

    // general register index
    // 4 bits, x0..x15
    typedef logic [3:0] gpr_addr_t;

    // raw 12-bit csr field of the instruction
    typedef logic [11:0] csr_addr_t;

    // slot inside the csr storage array
    // one slot per implemented machine CSR
    typedef enum logic [1:0] {
        idx_mstatus = 2'd0,
        idx_mtvec   = 2'd1,
        idx_mepc    = 2'd2,
        idx_mcause  = 2'd3
    } csr_idx_t;

endpackage

// File: hw/sys_decoder.sv
//////////////////////////////////////////////////////////////////////
// sys_decoder: combinational SYSTEM decode
// op, register fields, csr field and illegal flag
//////////////////////////////////////////////////////////////////////

`include "rv32e_consts.svh"

module sys_decoder (
    input  logic [`XLEN-1:0]      inst,
    output rv32e_pkg::sys_op_t    op,
    output rv32e_pkg::csr_addr_t  csr_addr,
    output rv32e_pkg::gpr_addr_t  rs1,
    output rv32e_pkg::gpr_addr_t  rd,
    output logic                  dec_illegal
);

    import rv32e_pkg::*;

    // instruction fields
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_f;
    logic [4:0]  rd_f;
    logic [11:0] imm;

    // I-type layout, shared by all SYSTEM forms
    assign opcode = inst[6:0];
    assign rd_f   = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1_f  = inst[19:15];
    assign imm    = inst[31:20];

    // register indices trimmed to RV32E width
    // bit 4 is checked below
    assign rs1 = rs1_f[3:0];
    assign rd  = rd_f[3:0];

    // csr field goes out as is
    // the CSR file decides whether it exists
    assign csr_addr = imm;

    always_comb begin
        op          = op_none;
        dec_illegal = 1'b0;

        if (opcode != `OPC_SYSTEM) begin
            // only SYSTEM is handled here
            dec_illegal = 1'b1;
        end else begin
            case (funct3)
                `F3_PRIV: begin
                    // priv group, told apart by the immediate
                    if (imm == `IMM_ECALL) begin
                        op = op_ecall;
                    end else if (imm == `IMM_MRET) begin
                        op = op_mret;
                    end else begin
                        // wfi, ebreak, sret etc not supported
                        dec_illegal = 1'b1;
                    end
                end
                `F3_CSRRW: begin
                    op = op_csrrw;
                end
                `F3_CSRRS: begin
                    op = op_csrrs;
                end
                default: begin
                    // csrrc and the immediate forms
                    dec_illegal = 1'b1;
                end
            endcase
        end

        // x16..x31 do not exist in RV32E
        if (rs1_f[4] || rd_f[4]) begin
            dec_illegal = 1'b1;
        end

        // illegal never carries an op
        if (dec_illegal) begin
            op = op_none;
        end
    end

endmodule

// File: hw/gpr_file.sv
//////////////////////////////////////////////////////////////////////
// gpr_file: RV32E general registers, one read and one write port
//////////////////////////////////////////////////////////////////////

`include "rv32e_consts.svh"

module gpr_file (
    input  logic                  clk,
    input  logic                  rst,
    input  rv32e_pkg::gpr_addr_t  rs1,
    output logic [`XLEN-1:0]      rs1_data,
    input  logic                  wen,
    input  rv32e_pkg::gpr_addr_t  waddr,
    input  logic [`XLEN-1:0]      wdata
);

    import rv32e_pkg::*;

    // x1..x15, no storage for x0
    logic [`XLEN-1:0] regs [1:`NUM_GPR-1];

    // write from the later stage
    always_ff @(posedge clk) begin
        if (rst) begin
            // whole file clears on reset
            for (int i = 1; i < `NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (waddr != gpr_addr_t'(0))) begin
            // writes to x0 fall through here
            regs[waddr] <= wdata;
        end
    end

    // async read
    // same-edge write shows up the next cycle
    always_comb begin
        if (rs1 == gpr_addr_t'(0)) begin
            // x0 hardwired to zero
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1];
        end
    end

endmodule

// File: hw/csr_file.sv
//////////////////////////////////////////////////////////////////////
// csr_file: mstatus, mtvec, mepc, mcause storage
// address decode, write data, ecall update and trap target
//////////////////////////////////////////////////////////////////////

`include "rv32e_consts.svh"

module csr_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wr,
    input  rv32e_pkg::sys_op_t    op,
    input  rv32e_pkg::csr_addr_t  csr_addr,
    input  logic [`XLEN-1:0]      rs1_data,
    input  logic [`XLEN-1:0]      pc,
    output logic [`XLEN-1:0]      csr_rdata,
    output logic                  csr_miss,
    output logic [`XLEN-1:0]      trap_target
);

    import rv32e_pkg::*;

    // one word per implemented CSR, indexed by csr_idx_t
    logic [`XLEN-1:0] csr_reg [4];

    csr_idx_t         idx;
    logic [`XLEN-1:0] csr_wdata;

    // 12-bit address to storage slot
    always_comb begin
        idx      = idx_mstatus;
        csr_miss = 1'b0;
        case (csr_addr)
            `CSR_MSTATUS: begin
                idx = idx_mstatus;
            end
            `CSR_MTVEC: begin
                idx = idx_mtvec;
            end
            `CSR_MEPC: begin
                idx = idx_mepc;
            end
            `CSR_MCAUSE: begin
                idx = idx_mcause;
            end
            default: begin
                // not implemented, top decides if it matters
                csr_miss = 1'b1;
            end
        endcase
    end

    // old value, goes back to rd
    assign csr_rdata = csr_reg[idx];

    // new value for csrrw / csrrs
    // csrrs with x0 rewrites the old value
    always_comb begin
        if (op == op_csrrs) begin
            csr_wdata = csr_rdata | rs1_data;
        end else begin
            csr_wdata = rs1_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_reg[idx_mstatus] <= `MSTATUS_RST;
            csr_reg[idx_mtvec]   <= '0;
            csr_reg[idx_mepc]    <= '0;
            csr_reg[idx_mcause]  <= `MCAUSE_RST;
        end else if (wr) begin
            case (op)
                op_csrrw, op_csrrs: begin
                    csr_reg[idx] <= csr_wdata;
                end
                op_ecall: begin
                    // trap entry: save pc and cause together
                    csr_reg[idx_mepc]   <= pc;
                    csr_reg[idx_mcause] <= `CAUSE_ECALL_M;
                end
                default: begin
                    // mret only redirects, no state change
                end
            endcase
        end
    end

    // redirect target
    // ecall jumps to the handler, mret returns to mepc
    always_comb begin
        if (op == op_ecall) begin
            trap_target = csr_reg[idx_mtvec];
        end else begin
            trap_target = csr_reg[idx_mepc];
        end
    end

endmodule

// File: hw/sys_idu.sv
//////////////////////////////////////////////////////////////////////
// sys_idu: SYSTEM part of the RV32E decode stage
// decoder, gpr file, csr file and the one-cycle output stage
//////////////////////////////////////////////////////////////////////

`include "rv32e_consts.svh"

module sys_idu (
    input  logic                  clk,
    input  logic                  rst,
    // instruction strobe from fetch
    input  logic                  inst_valid,
    input  logic [`XLEN-1:0]      inst,
    input  logic [`XLEN-1:0]      pc,
    // register writeback from the later stage
    input  logic                  wb_en,
    input  rv32e_pkg::gpr_addr_t  wb_addr,
    input  logic [`XLEN-1:0]      wb_data,
    // results, one cycle after inst_valid
    output logic                  out_valid,
    output logic                  illegal,
    output logic                  rd_wen,
    output rv32e_pkg::gpr_addr_t  rd_addr,
    output logic [`XLEN-1:0]      rd_data,
    output logic                  redirect,
    output logic [`XLEN-1:0]      redirect_pc
);

    import rv32e_pkg::*;

    // decoder outputs
    sys_op_t   op;
    csr_addr_t csr_addr;
    gpr_addr_t rs1;
    gpr_addr_t rd;
    logic      dec_illegal;

    // register and csr reads
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] csr_rdata;
    logic [`XLEN-1:0] trap_target;
    logic             csr_miss;

    // legality and qualified strobes
    logic csr_op;
    logic trap_op;
    logic legal;
    logic csr_wr;

    sys_decoder u_dec (
        .inst        (inst),
        .op          (op),
        .csr_addr    (csr_addr),
        .rs1         (rs1),
        .rd          (rd),
        .dec_illegal (dec_illegal)
    );

    gpr_file u_gpr (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs1_data (rs1_data),
        .wen      (wb_en),
        .waddr    (wb_addr),
        .wdata    (wb_data)
    );

    csr_file u_csr (
        .clk         (clk),
        .rst         (rst),
        .wr          (csr_wr),
        .op          (op),
        .csr_addr    (csr_addr),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .csr_rdata   (csr_rdata),
        .csr_miss    (csr_miss),
        .trap_target (trap_target)
    );

    assign csr_op  = (op == op_csrrw) || (op == op_csrrs);
    assign trap_op = (op == op_ecall) || (op == op_mret);

    // csr address only matters for the csr ops
    // ecall/mret put their immediate in that field
    assign legal = !dec_illegal && !(csr_op && csr_miss);

    // illegal instructions never touch CSR state
    assign csr_wr = inst_valid && legal;

    // control part of the output stage
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            illegal   <= 1'b0;
            rd_wen    <= 1'b0;
            redirect  <= 1'b0;
        end else begin
            out_valid <= inst_valid;
            illegal   <= inst_valid && !legal;
            // no writeback request for rd == x0
            rd_wen    <= csr_wr && csr_op && (rd != gpr_addr_t'(0));
            redirect  <= csr_wr && trap_op;
        end
    end

    // payload, only meaningful with the flags above
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            rd_addr     <= rd;
            rd_data     <= csr_rdata;
            redirect_pc <= trap_target;
        end
    end

endmodule

// File: test/sys_idu_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for sys_idu with clock, reset, stimulus table, reference
// model, out_valid wait with timeout, field checks and summary
//////////////////////////////////////////////////////////////////////

`include "rv32e_consts.svh"

module sys_idu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_ROWS = 32;
    // negedges allowed between issue and out_valid
    localparam int TIMEOUT = 20;

    // one stimulus row
    // writeback goes one cycle ahead of the instruction
    typedef struct packed {
        logic        wb_en;
        logic [3:0]  wb_addr;
        logic [31:0] wb_data;
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [11:0] imm;
        logic [31:0] pc;
        logic        chain;
    } row_t;

    // expected response of one row
    typedef struct packed {
        logic        illegal;
        logic        rd_wen;
        logic [3:0]  rd_addr;
        logic [31:0] rd_data;
        logic        rd_data_vld;
        logic        redirect;
        logic [31:0] redirect_pc;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        wb_en;
    logic [3:0]  wb_addr;
    logic [31:0] wb_data;
    logic        out_valid;
    logic        illegal;
    logic        rd_wen;
    logic [3:0]  rd_addr;
    logic [31:0] rd_data;
    logic        redirect;
    logic [31:0] redirect_pc;

    // table and expected values
    row_t    rows [MAX_ROWS];
    expect_t exps [MAX_ROWS];
    string   names [MAX_ROWS];
    int      num_rows;

    // writeback staged for the next added row
    logic        pend_wb_en;
    logic [3:0]  pend_wb_addr;
    logic [31:0] pend_wb_data;

    // reference model state
    logic [31:0] gpr_m [16];
    logic [31:0] m_mstatus;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;

    integer seed = 32'hd7b6_f7e7;
    int     row_errors;
    int     total_errors;
    int     rows_ok;
    int     rows_bad;

    sys_idu dut_i (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .out_valid   (out_valid),
        .illegal     (illegal),
        .rd_wen      (rd_wen),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .redirect    (redirect),
        .redirect_pc (redirect_pc)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // only the four machine CSRs exist
    function automatic logic csr_known(input logic [11:0] addr);
        return (addr == `CSR_MSTATUS) || (addr == `CSR_MTVEC) ||
               (addr == `CSR_MEPC) || (addr == `CSR_MCAUSE);
    endfunction

    function automatic logic [31:0] csr_peek(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS: return m_mstatus;
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            default:      return m_mcause;
        endcase
    endfunction

    task automatic csr_poke(input logic [11:0] addr, input logic [31:0] value);
        case (addr)
            `CSR_MSTATUS: m_mstatus = value;
            `CSR_MTVEC:   m_mtvec = value;
            `CSR_MEPC:    m_mepc = value;
            default:      m_mcause = value;
        endcase
    endtask

    // stage a register write ahead of the next row
    task automatic preload(input logic [3:0] addr, input logic [31:0] data);
        pend_wb_en   = 1'b1;
        pend_wb_addr = addr;
        pend_wb_data = data;
    endtask

    task automatic add_row(input string name, input logic [6:0] opcode,
                           input logic [2:0] funct3, input logic [4:0] rs1,
                           input logic [4:0] rd, input logic [11:0] imm,
                           input logic chain);
        row_t r;
        r         = '0;
        r.wb_en   = pend_wb_en;
        r.wb_addr = pend_wb_addr;
        r.wb_data = pend_wb_data;
        r.opcode  = opcode;
        r.funct3  = funct3;
        r.rs1     = rs1;
        r.rd      = rd;
        r.imm     = imm;
        // distinct word-aligned pc per row
        r.pc      = 32'h0000_0100 + (32'(num_rows) << 2);
        r.chain   = chain;
        rows[num_rows]  = r;
        names[num_rows] = name;
        num_rows++;
        pend_wb_en = 1'b0;
    endtask

    task automatic csr_row(input string name, input logic [2:0] funct3,
                           input logic [11:0] csr, input logic [4:0] rs1,
                           input logic [4:0] rd, input logic chain);
        add_row(name, `OPC_SYSTEM, funct3, rs1, rd, csr, chain);
    endtask

    task automatic priv_row(input string name, input logic [11:0] imm, input logic chain);
        add_row(name, `OPC_SYSTEM, `F3_PRIV, 5'd0, 5'd0, imm, chain);
    endtask

    task automatic build_table();
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        logic [31:0] v4;
        v1 = $random(seed);
        v2 = $random(seed);
        v3 = $random(seed);
        v4 = $random(seed);
        num_rows   = 0;
        pend_wb_en = 1'b0;
        // reset values
        csr_row("read mstatus", `F3_CSRRS, `CSR_MSTATUS, 5'd0, 5'd1, 1'b0);
        csr_row("read mtvec", `F3_CSRRS, `CSR_MTVEC, 5'd0, 5'd1, 1'b0);
        csr_row("read mepc", `F3_CSRRS, `CSR_MEPC, 5'd0, 5'd1, 1'b0);
        csr_row("read mcause", `F3_CSRRS, `CSR_MCAUSE, 5'd0, 5'd1, 1'b0);
        // csrrw then csrrs on mtvec
        preload(4'd5, v1);
        csr_row("csrrw mtvec x5", `F3_CSRRW, `CSR_MTVEC, 5'd5, 5'd2, 1'b0);
        preload(4'd6, v2);
        csr_row("csrrs mtvec x6", `F3_CSRRS, `CSR_MTVEC, 5'd6, 5'd3, 1'b0);
        csr_row("readback mtvec", `F3_CSRRS, `CSR_MTVEC, 5'd0, 5'd4, 1'b0);
        csr_row("csrrw mepc rd=x0", `F3_CSRRW, `CSR_MEPC, 5'd5, 5'd0, 1'b0);
        priv_row("mret to csrrw mepc", `IMM_MRET, 1'b0);
        // trap entry and return
        // mcause moved off its reset value so the ecall update shows
        csr_row("csrrw mcause x6", `F3_CSRRW, `CSR_MCAUSE, 5'd6, 5'd0, 1'b0);
        priv_row("ecall", `IMM_ECALL, 1'b0);
        csr_row("read mepc after ecall", `F3_CSRRS, `CSR_MEPC, 5'd0, 5'd1, 1'b0);
        csr_row("read mcause after ecall", `F3_CSRRS, `CSR_MCAUSE, 5'd0, 5'd1, 1'b0);
        priv_row("mret to ecall pc", `IMM_MRET, 1'b0);
        // illegal forms
        // x1 given a value so a leak would show
        preload(4'd1, v4);
        add_row("non-SYSTEM opcode", 7'b0110011, 3'd0, 5'd5, 5'd1, 12'h000, 1'b0);
        csr_row("csrrw rs1=x17", `F3_CSRRW, `CSR_MTVEC, 5'd17, 5'd1, 1'b0);
        csr_row("csrrw rd=x20", `F3_CSRRW, `CSR_MTVEC, 5'd5, 5'd20, 1'b0);
        csr_row("csrrw unknown csr", `F3_CSRRW, 12'h340, 5'd5, 5'd1, 1'b0);
        csr_row("csrrc mtvec", 3'd3, `CSR_MTVEC, 5'd5, 5'd1, 1'b0);
        priv_row("wfi", 12'h105, 1'b0);
        csr_row("mtvec after illegal", `F3_CSRRS, `CSR_MTVEC, 5'd0, 5'd1, 1'b0);
        csr_row("mepc after illegal", `F3_CSRRS, `CSR_MEPC, 5'd0, 5'd1, 1'b0);
        csr_row("mstatus after illegal", `F3_CSRRS, `CSR_MSTATUS, 5'd0, 5'd1, 1'b0);
        // back to back
        // each row issued the cycle after the one before
        preload(4'd7, v3);
        csr_row("burst csrrw mtvec x7", `F3_CSRRW, `CSR_MTVEC, 5'd7, 5'd8, 1'b0);
        csr_row("burst csrrs mtvec x6", `F3_CSRRS, `CSR_MTVEC, 5'd6, 5'd9, 1'b1);
        csr_row("burst read mtvec", `F3_CSRRS, `CSR_MTVEC, 5'd0, 5'd10, 1'b1);
        priv_row("burst ecall", `IMM_ECALL, 1'b1);
        csr_row("burst read mepc", `F3_CSRRS, `CSR_MEPC, 5'd0, 5'd11, 1'b1);
        priv_row("burst mret", `IMM_MRET, 1'b1);
    endtask

    // reference model walks the table in issue order
    task automatic predict_all();
        row_t        r;
        expect_t     e;
        logic        is_csr;
        logic        is_priv;
        logic        bad;
        logic [31:0] src;
        logic [31:0] old;
        for (int k = 0; k < 16; k++) begin
            gpr_m[k] = '0;
        end
        m_mstatus = `MSTATUS_RST;
        m_mtvec   = '0;
        m_mepc    = '0;
        m_mcause  = `MCAUSE_RST;
        for (int i = 0; i < num_rows; i++) begin
            r = rows[i];
            e = '0;
            // x0 never takes a write
            if (r.wb_en && (r.wb_addr != 4'd0)) begin
                gpr_m[r.wb_addr] = r.wb_data;
            end
            src     = gpr_m[r.rs1[3:0]];
            is_csr  = (r.funct3 == `F3_CSRRW) || (r.funct3 == `F3_CSRRS);
            is_priv = (r.funct3 == `F3_PRIV);
            bad = (r.opcode != `OPC_SYSTEM) || r.rs1[4] || r.rd[4] || !(is_csr || is_priv);
            bad = bad || (is_priv && (r.imm != `IMM_ECALL) && (r.imm != `IMM_MRET));
            bad = bad || (is_csr && !csr_known(r.imm));
            e.illegal = bad;
            if (!bad && is_csr) begin
                old           = csr_peek(r.imm);
                e.rd_data     = old;
                e.rd_data_vld = 1'b1;
                e.rd_wen      = (r.rd[3:0] != 4'd0);
                e.rd_addr     = r.rd[3:0];
                if (r.funct3 == `F3_CSRRW) begin
                    csr_poke(r.imm, src);
                end else begin
                    csr_poke(r.imm, old | src);
                end
            end else if (!bad && (r.imm == `IMM_ECALL)) begin
                // jump to the handler and remember where the trap came from
                e.redirect    = 1'b1;
                e.redirect_pc = m_mtvec;
                m_mepc        = r.pc;
                m_mcause      = `CAUSE_ECALL_M;
            end else if (!bad) begin
                e.redirect    = 1'b1;
                e.redirect_pc = m_mepc;
            end
            exps[i] = e;
        end
    endtask

    task automatic drive_row(input int i);
        row_t r;
        r = rows[i];
        // writeback lands one cycle before the read
        if (r.wb_en) begin
            wb_en   = 1'b1;
            wb_addr = r.wb_addr;
            wb_data = r.wb_data;
            @(negedge clk);
            wb_en = 1'b0;
        end
        inst       = {r.imm, r.rs1, r.funct3, r.rd, r.opcode};
        pc         = r.pc;
        inst_valid = 1'b1;
    endtask

    task automatic check_field(input string sig, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("error: t=%0t %s got %h expected %h", $time, sig, got, want);
            row_errors++;
        end
    endtask

    task automatic check_row(input int i);
        expect_t e;
        e = exps[i];
        check_field("illegal", 32'(illegal), 32'(e.illegal));
        check_field("rd_wen", 32'(rd_wen), 32'(e.rd_wen));
        check_field("redirect", 32'(redirect), 32'(e.redirect));
        if (e.rd_wen) begin
            check_field("rd_addr", 32'(rd_addr), 32'(e.rd_addr));
        end
        if (e.rd_data_vld) begin
            check_field("rd_data", rd_data, e.rd_data);
        end
        if (e.redirect) begin
            check_field("redirect_pc", redirect_pc, e.redirect_pc);
        end
    endtask

    initial begin
        int n;
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = '0;
        wb_en        = 1'b0;
        wb_addr      = '0;
        wb_data      = '0;
        total_errors = 0;
        rows_ok      = 0;
        rows_bad     = 0;
        build_table();
        predict_all();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < num_rows; i++) begin
            row_errors = 0;
            drive_row(i);
            @(negedge clk);
            // a chained next row raises it again at this same edge
            inst_valid = 1'b0;
            n = 0;
            while (!out_valid && (n < TIMEOUT)) begin
                @(negedge clk);
                n++;
            end
            if (!out_valid) begin
                $display("timeout: out_valid never rose for row %0d (%s)", i, names[i]);
                $display("Test failed");
                $finish;
            end
            check_field("out_valid latency", 32'(n + 1), 32'd1);
            check_row(i);
            $display("row %2d  %-26s %s", i, names[i], (row_errors == 0) ? "ok" : "mismatch");
            total_errors += row_errors;
            if (row_errors == 0) begin
                rows_ok++;
            end else begin
                rows_bad++;
            end
            // idle cycle unless the next row follows directly
            if ((i + 1 < num_rows) && !rows[i + 1].chain) begin
                @(negedge clk);
            end
        end
        $display("rows %0d, ok %0d, mismatched %0d, errors %0d",
                 num_rows, rows_ok, rows_bad, total_errors);
        if (rows_bad == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+hw
hw/rv32e_pkg.sv
hw/sys_decoder.sv
hw/gpr_file.sv
hw/csr_file.sv
hw/sys_idu.sv
test/sys_idu_tb.sv

// File: Makefile
# Verilator flow for the sys_idu testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := sys_idu_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# run, keep the log, then look for the failure line
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
